// ==== verilog/MicrorocPkg.sv ====
package MicrorocPkg;

	////////////////////////////////////////////////////////////////////////////
	// Register geometry of the MICROROC serial port
	////////////////////////////////////////////////////////////////////////////
	localparam int slowControlLength = 592;                            // SR select high
	localparam int readScopeLength   = 64;                             // SR select low
	localparam int wordWidth         = 16;                             // Bits per FIFO word
	localparam int slowControlWords  = slowControlLength / wordWidth;  // 37 words
	localparam int readScopeWords    = readScopeLength / wordWidth;    // 4 words
	localparam int wordCountWidth    = 6;                              // Holds up to 37

	// Config FIFO between Clk and SlowClock
	localparam int fifoDepth     = 64;                                 // Never fills on one load
	localparam int fifoAddrWidth = 6;

	////////////////////////////////////////////////////////////////////////////
	// Serializer state codes
	////////////////////////////////////////////////////////////////////////////
	localparam int stateWidth = 3;
	localparam logic [stateWidth-1:0] stateIdle       = 3'd0;
	localparam logic [stateWidth-1:0] stateResetPulse = 3'd1;          // SR_RSTB low
	localparam logic [stateWidth-1:0] stateFetch      = 3'd2;          // Read request
	localparam logic [stateWidth-1:0] stateWaitData   = 3'd3;          // FIFO read latency
	localparam logic [stateWidth-1:0] stateShiftLow   = 3'd4;          // SR_IN settles
	localparam logic [stateWidth-1:0] stateShiftHigh  = 3'd5;          // SR_CK high
	localparam logic [stateWidth-1:0] stateDone       = 3'd6;          // Done pulse

endpackage

// ==== verilog/ConfigFifoIf.sv ====
interface ConfigFifoIf;

	// Write side, Clk domain
	logic                              writeEn;     // One word per Clk edge
	logic [MicrorocPkg::wordWidth-1:0] writeData;   // Next word, MSW first

	// Read side, SlowClock domain
	logic                              readEn;      // Only while empty is low
	logic [MicrorocPkg::wordWidth-1:0] readData;    // Valid the cycle after readEn
	logic                              empty;       // Read domain view

	modport writer (
		output writeEn,
		output writeData
	);

	modport reader (
		output readEn,
		input  readData,
		input  empty
	);

	modport fifo (
		input  writeEn,
		input  writeData,
		input  readEn,
		output readData,
		output empty
	);

endinterface

// ==== verilog/PulseSynchronous.sv ====
module PulseSynchronous (
	input  logic ClkSource,
	input  logic ClkDestination,
	input  logic rstN,
	input  logic pulseSource,        // One ClkSource cycle
	output logic pulseDestination    // One ClkDestination cycle
);

	logic       toggleSource;        // Flips once per source pulse
	logic [2:0] syncDestination;     // Bits 0 and 1 sync, bit 2 edge history

	always_ff @(posedge ClkSource or negedge rstN) begin
		if (!rstN) begin
			toggleSource <= 1'b0;
		end else if (pulseSource) begin
			toggleSource <= ~toggleSource;
		end
	end

	always_ff @(posedge ClkDestination or negedge rstN) begin
		if (!rstN) begin
			syncDestination <= '0;
		end else begin
			syncDestination <= {syncDestination[1:0], toggleSource};
		end
	end

	// Either toggle edge gives one pulse
	assign pulseDestination = syncDestination[2] ^ syncDestination[1];

endmodule

// ==== verilog/ParameterGenerator.sv ====
module ParameterGenerator (
	input  logic                                      Clk,
	input  logic                                      rstN,
	input  logic                                      select,        // 1 slow control, 0 scope
	input  logic                                      loadStart,     // One Clk pulse
	input  logic [MicrorocPkg::slowControlLength-1:0] slowControlParameter,
	input  logic [MicrorocPkg::readScopeLength-1:0]   readScopeChannel,
	ConfigFifoIf.writer                               fifo,
	output logic                                      done           // After last word
);

	logic [MicrorocPkg::slowControlLength-1:0] shiftReg;   // Current word on top
	logic [MicrorocPkg::wordCountWidth-1:0]    wordsLeft;  // Words still to write
	logic                                      busy;       // Writing words
	logic                                      startLoad;  // Accepted start
	logic                                      lastWord;

	assign startLoad = loadStart && !busy;                  // Start ignored while busy
	assign lastWord  = (wordsLeft == MicrorocPkg::wordCountWidth'(1));

	// Latch selected vector, then move one word up per write
	always_ff @(posedge Clk) begin
		if (startLoad) begin
			if (select) begin
				shiftReg <= slowControlParameter;
			end else begin
				shiftReg <= {readScopeChannel,                  // Left aligned
					{(MicrorocPkg::slowControlLength - MicrorocPkg::readScopeLength){1'b0}}};
			end
		end else if (busy) begin
			shiftReg <= shiftReg << MicrorocPkg::wordWidth;     // Next word to top
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			busy      <= 1'b0;
			wordsLeft <= '0;
			done      <= 1'b0;
		end else begin
			done <= busy && lastWord;                           // Cycle after last write
			if (startLoad) begin
				busy      <= 1'b1;
				wordsLeft <= select ?
					MicrorocPkg::wordCountWidth'(MicrorocPkg::slowControlWords) :
					MicrorocPkg::wordCountWidth'(MicrorocPkg::readScopeWords);
			end else if (busy) begin
				wordsLeft <= wordsLeft - 1'b1;
				if (lastWord) begin
					busy <= 1'b0;
				end
			end
		end
	end

	assign fifo.writeEn   = busy;                           // One word per busy cycle
	assign fifo.writeData = shiftReg[MicrorocPkg::slowControlLength-1 -: MicrorocPkg::wordWidth];

endmodule

// ==== verilog/ConfigParameterFifo.sv ====
module ConfigParameterFifo (
	input  logic       Clk,        // Write clock
	input  logic       SlowClock,  // Read clock
	input  logic       rstN,
	ConfigFifoIf.fifo  fifo
);

	logic [MicrorocPkg::wordWidth-1:0] mem [MicrorocPkg::fifoDepth];  // Word storage

	// Pointers carry one wrap bit above the address
	logic [MicrorocPkg::fifoAddrWidth:0] wrBin;
	logic [MicrorocPkg::fifoAddrWidth:0] wrBinNext;
	logic [MicrorocPkg::fifoAddrWidth:0] wrGray;
	logic [MicrorocPkg::fifoAddrWidth:0] wrGrayNext;
	logic [MicrorocPkg::fifoAddrWidth:0] rdBin;
	logic [MicrorocPkg::fifoAddrWidth:0] rdBinNext;
	logic [MicrorocPkg::fifoAddrWidth:0] rdGray;
	logic [MicrorocPkg::fifoAddrWidth:0] rdGrayNext;
	logic [MicrorocPkg::fifoAddrWidth:0] rdGrayMeta;   // First sync stage in Clk
	logic [MicrorocPkg::fifoAddrWidth:0] rdGraySync;   // Read pointer seen by writer
	logic [MicrorocPkg::fifoAddrWidth:0] wrGrayMeta;   // First sync stage in SlowClock
	logic [MicrorocPkg::fifoAddrWidth:0] wrGraySync;   // Write pointer seen by reader
	logic                                full;
	logic                                doWrite;
	logic                                doRead;

	////////////////////////////////////////////////////////////////////////////
	// Write domain
	////////////////////////////////////////////////////////////////////////////
	// Full when Gray pointers differ only in the two top bits
	assign full = (wrGray == {~rdGraySync[MicrorocPkg::fifoAddrWidth -: 2],
		rdGraySync[MicrorocPkg::fifoAddrWidth-2:0]});
	assign doWrite    = fifo.writeEn && !full;
	assign wrBinNext  = doWrite ? wrBin + 1'b1 : wrBin;
	assign wrGrayNext = wrBinNext ^ (wrBinNext >> 1);       // Binary to Gray

	always_ff @(posedge Clk) begin
		if (doWrite) begin
			mem[wrBin[MicrorocPkg::fifoAddrWidth-1:0]] <= fifo.writeData;
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			wrBin      <= '0;
			wrGray     <= '0;
			rdGrayMeta <= '0;
			rdGraySync <= '0;
		end else begin
			wrBin      <= wrBinNext;
			wrGray     <= wrGrayNext;
			rdGrayMeta <= rdGray;                              // Two-flop sync
			rdGraySync <= rdGrayMeta;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read domain
	////////////////////////////////////////////////////////////////////////////
	assign fifo.empty = (rdGray == wrGraySync);             // Pessimistic by sync delay
	assign doRead     = fifo.readEn && !fifo.empty;
	assign rdBinNext  = doRead ? rdBin + 1'b1 : rdBin;
	assign rdGrayNext = rdBinNext ^ (rdBinNext >> 1);

	always_ff @(posedge SlowClock) begin
		if (doRead) begin
			fifo.readData <= mem[rdBin[MicrorocPkg::fifoAddrWidth-1:0]];  // One cycle latency
		end
	end

	always_ff @(posedge SlowClock or negedge rstN) begin
		if (!rstN) begin
			rdBin      <= '0;
			rdGray     <= '0;
			wrGrayMeta <= '0;
			wrGraySync <= '0;
		end else begin
			rdBin      <= rdBinNext;
			rdGray     <= rdGrayNext;
			wrGrayMeta <= wrGray;                              // Two-flop sync
			wrGraySync <= wrGrayMeta;
		end
	end

endmodule

// ==== verilog/BitShiftOut.sv ====
module BitShiftOut (
	input  logic         SlowClock,
	input  logic         rstN,
	input  logic         shiftStart,   // From pulse sync
	ConfigFifoIf.reader  fifo,
	output logic         serialClock,  // SR_CK
	output logic         serialReset,  // SR_RSTB, active low
	output logic         serialData,   // SR_IN
	output logic         shiftDone     // One SlowClock pulse
);

	logic [MicrorocPkg::stateWidth-1:0]       state;
	logic [MicrorocPkg::stateWidth-1:0]       stateNext;
	logic [MicrorocPkg::wordWidth-1:0]        shiftReg;   // MSB goes out first
	logic [$clog2(MicrorocPkg::wordWidth)-1:0] bitCount;  // Bit within word
	logic                                     wordSeen;   // A word went out this load

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		stateNext = state;
		case (state)
			MicrorocPkg::stateIdle: begin
				if (shiftStart) begin
					stateNext = MicrorocPkg::stateResetPulse;
				end
			end
			MicrorocPkg::stateResetPulse: stateNext = MicrorocPkg::stateFetch;
			MicrorocPkg::stateFetch: begin
				if (!fifo.empty) begin
					stateNext = MicrorocPkg::stateWaitData;
				end else if (wordSeen) begin
					stateNext = MicrorocPkg::stateDone;         // Load used up
				end                                            // Else hold, SR_CK low
			end
			MicrorocPkg::stateWaitData: stateNext = MicrorocPkg::stateShiftLow;
			MicrorocPkg::stateShiftLow: stateNext = MicrorocPkg::stateShiftHigh;
			MicrorocPkg::stateShiftHigh: begin
				stateNext = (&bitCount) ? MicrorocPkg::stateFetch : MicrorocPkg::stateShiftLow;
			end
			MicrorocPkg::stateDone: stateNext = MicrorocPkg::stateIdle;
			default: stateNext = MicrorocPkg::stateIdle;       // Unused codes recover
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State, shift register and bit counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge SlowClock or negedge rstN) begin
		if (!rstN) begin
			state    <= MicrorocPkg::stateIdle;
			shiftReg <= '0;                                    // SR_IN low out of reset
			bitCount <= '0;
			wordSeen <= 1'b0;
		end else begin
			state <= stateNext;
			case (state)
				MicrorocPkg::stateResetPulse: wordSeen <= 1'b0;
				MicrorocPkg::stateWaitData: begin
					shiftReg <= fifo.readData;                     // Word valid now
					bitCount <= '0;
				end
				MicrorocPkg::stateShiftHigh: begin
					shiftReg <= shiftReg << 1;                     // Changes as SR_CK falls
					bitCount <= bitCount + 1'b1;
					if (&bitCount) begin
						wordSeen <= 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	assign fifo.readEn = (state == MicrorocPkg::stateFetch) && !fifo.empty;

	// Pin decode
	assign serialClock = (state == MicrorocPkg::stateShiftHigh);
	assign serialReset = (state != MicrorocPkg::stateResetPulse);
	assign serialData  = shiftReg[MicrorocPkg::wordWidth-1];
	assign shiftDone   = (state == MicrorocPkg::stateDone);

endmodule

// ==== verilog/SlowControlAndReadScopeSet.sv ====
module SlowControlAndReadScopeSet (
	input  logic                                      Clk,
	input  logic                                      SlowClock,   // MICROROC serial clock
	input  logic                                      rstN,
	input  logic                                      slowControlOrReadScopeSelect,
	input  logic                                      parameterLoadStart,
	input  logic [MicrorocPkg::slowControlLength-1:0] slowControlParameter,  // MSB first
	input  logic [MicrorocPkg::readScopeLength-1:0]   readScopeChannel,      // MSB first
	output logic                                      parameterLoadDone,
	output logic                                      SR_SELECT,   // 1 slow control, 0 scope
	output logic                                      SR_RSTB,     // Register reset
	output logic                                      SR_CK,       // Register clock
	output logic                                      SR_IN        // Register data
);

	logic generatorDone;   // Clk domain, all words written
	logic shiftStart;      // SlowClock domain

	ConfigFifoIf configFifo ();

	ParameterGenerator paramGen (
		.Clk                  (Clk),
		.rstN                 (rstN),
		.select               (slowControlOrReadScopeSelect),
		.loadStart            (parameterLoadStart),
		.slowControlParameter (slowControlParameter),
		.readScopeChannel     (readScopeChannel),
		.fifo                 (configFifo.writer),
		.done                 (generatorDone)
	);

	ConfigParameterFifo configParameter (
		.Clk       (Clk),
		.SlowClock (SlowClock),
		.rstN      (rstN),
		.fifo      (configFifo.fifo)
	);

	PulseSynchronous pulseSync (
		.ClkSource        (Clk),
		.ClkDestination   (SlowClock),
		.rstN             (rstN),
		.pulseSource      (generatorDone),
		.pulseDestination (shiftStart)
	);

	BitShiftOut parameterShiftOut (
		.SlowClock   (SlowClock),
		.rstN        (rstN),
		.shiftStart  (shiftStart),
		.fifo        (configFifo.reader),
		.serialClock (SR_CK),
		.serialReset (SR_RSTB),
		.serialData  (SR_IN),
		.shiftDone   (parameterLoadDone)
	);

	assign SR_SELECT = slowControlOrReadScopeSelect;   // Straight to the chip pin

endmodule

// ==== tests/SlowControl_props.sv ====
module SlowControlProps (
	input logic SlowClock,
	input logic rstN,
	input logic serialClock,    // SR_CK
	input logic serialReset,    // SR_RSTB active low
	input logic shiftDone       // Load done pulse
);

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////////////////////////////////////////
	// Serial pin rules
	////////////////////////////////////////////////////////////////////////////
	noClockInReset: assert property (@(posedge SlowClock) disable iff (!rstN)
		$rose(serialClock) |-> serialReset && $past(serialReset))   // Reset released first
		else $error("SR_CK rose while or right after SR_RSTB was low");

	resetOneCycle: assert property (@(posedge SlowClock) disable iff (!rstN)
		$fell(serialReset) |=> serialReset)                  // Single cycle reset pulse
		else $error("SR_RSTB stayed low for more than one SlowClock cycle");

	doneOneCycle: assert property (@(posedge SlowClock) disable iff (!rstN)
		shiftDone |=> !shiftDone)
		else $error("parameterLoadDone stayed high for more than one SlowClock cycle");

endmodule

bind BitShiftOut SlowControlProps props (
	.SlowClock   (SlowClock),
	.rstN        (rstN),
	.serialClock (serialClock),
	.serialReset (serialReset),
	.shiftDone   (shiftDone)
);

// ==== tests/SlowControlTb.sv ====
module SlowControlTb;

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////////////////////////////////////////
	// Case table
	////////////////////////////////////////////////////////////////////////////
	localparam int numCases    = 6;
	localparam int doneTimeout = 4000;                               // SlowClock cycles per load
	localparam bit caseSelect [numCases] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};  // 1 SC
	localparam int caseOffset [numCases] = '{0, 7, 13, 3, 21, 9};    // LFSR bits dropped
	localparam int caseBits   [numCases] = '{592, 64, 592, 64, 592, 64};

	logic                                      Clk;
	logic                                      SlowClock;
	logic                                      rstN;
	logic                                      slowControlOrReadScopeSelect;
	logic                                      parameterLoadStart;
	logic [MicrorocPkg::slowControlLength-1:0] slowControlParameter;
	logic [MicrorocPkg::readScopeLength-1:0]   readScopeChannel;
	logic                                      parameterLoadDone;
	logic                                      SR_SELECT;
	logic                                      SR_RSTB;
	logic                                      SR_CK;
	logic                                      SR_IN;

	logic [31:0] lfsrState;          // Pattern source
	logic        captured [$];       // SR_IN at each SR_CK rise
	int          resetPulses;        // SR_RSTB falls in this load

	SlowControlAndReadScopeSet dut (
		.Clk                          (Clk),
		.SlowClock                    (SlowClock),
		.rstN                         (rstN),
		.slowControlOrReadScopeSelect (slowControlOrReadScopeSelect),
		.parameterLoadStart           (parameterLoadStart),
		.slowControlParameter         (slowControlParameter),
		.readScopeChannel             (readScopeChannel),
		.parameterLoadDone            (parameterLoadDone),
		.SR_SELECT                    (SR_SELECT),
		.SR_RSTB                      (SR_RSTB),
		.SR_CK                        (SR_CK),
		.SR_IN                        (SR_IN)
	);

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;                                       // 100 ns
	end

	initial begin
		SlowClock = 1'b0;
		forever #150 SlowClock = ~SlowClock;                          // 300 ns
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic showMismatch(input string signalName, input longint expected,
		input longint actual);
		abortRun($sformatf("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
			$time, signalName, expected, actual));
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic nextRandomBit();
		logic outBit;
		outBit    = lfsrState[31];
		lfsrState = {lfsrState[30:0],
			lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
		return outBit;
	endfunction

	// Both vectors change so the unselected one must stay out of the stream
	task automatic fillVectors(input int dropBits);
		repeat (dropBits) begin
			void'(nextRandomBit());
		end
		for (int i = MicrorocPkg::slowControlLength - 1; i >= 0; i--) begin
			slowControlParameter[i] = nextRandomBit();
		end
		for (int i = MicrorocPkg::readScopeLength - 1; i >= 0; i--) begin
			readScopeChannel[i] = nextRandomBit();
		end
	endtask

	task automatic waitForLoadDone();
		int cycles;
		cycles = 0;
		do begin
			@(negedge SlowClock);                                      // Done stable here
			cycles++;
		end while (parameterLoadDone !== 1'b1 && cycles < doneTimeout);
		assert (parameterLoadDone === 1'b1) else
			abortRun($sformatf("parameterLoadDone did not pulse within %0d SlowClock cycles",
				doneTimeout));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Serial capture
	////////////////////////////////////////////////////////////////////////////
	always @(posedge SR_CK) begin
		if (rstN) begin
			captured.push_back(SR_IN);                                 // SR_IN settled a cycle ago
		end
	end

	always @(negedge SR_RSTB) begin
		if (rstN) begin
			resetPulses++;
			assert (captured.size() == 0) else
				abortRun("SR_RSTB pulsed low after SR_CK had already started shifting");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	////////////////////////////////////////////////////////////////////////////
	initial begin
		logic expBit;
		lfsrState                    = 32'had1a_93a7;
		rstN                         = 1'b0;
		slowControlOrReadScopeSelect = 1'b0;
		parameterLoadStart           = 1'b0;
		slowControlParameter         = '0;
		readScopeChannel             = '0;
		resetPulses                  = 0;
		repeat (5) @(posedge Clk);
		#5 rstN = 1'b1;

		// Idle pins after reset
		@(negedge Clk);
		assert (SR_RSTB === 1'b1) else showMismatch("SR_RSTB", 1, SR_RSTB);
		assert (SR_CK === 1'b0) else showMismatch("SR_CK", 0, SR_CK);
		assert (SR_IN === 1'b0) else showMismatch("SR_IN", 0, SR_IN);
		assert (parameterLoadDone === 1'b0) else showMismatch("parameterLoadDone", 0,
			parameterLoadDone);
		assert (SR_SELECT === 1'b0) else showMismatch("SR_SELECT", 0, SR_SELECT);
		@(posedge Clk);
		#5 slowControlOrReadScopeSelect = 1'b1;
		@(negedge Clk);
		assert (SR_SELECT === 1'b1) else showMismatch("SR_SELECT", 1, SR_SELECT);
		captured.delete();
		resetPulses = 0;

		for (int c = 0; c < numCases; c++) begin
			@(posedge Clk);
			#5;
			slowControlOrReadScopeSelect = caseSelect[c];
			fillVectors(caseOffset[c]);
			@(posedge Clk);
			#5 parameterLoadStart = 1'b1;                             // One Clk pulse
			@(posedge Clk);
			#5 parameterLoadStart = 1'b0;
			waitForLoadDone();

			assert (resetPulses == 1) else showMismatch("SR_RSTB low pulses", 1, resetPulses);
			assert (captured.size() == caseBits[c]) else
				showMismatch("SR_CK rising edges", caseBits[c], captured.size());
			for (int i = 0; i < caseBits[c]; i++) begin
				expBit = caseSelect[c] ?                                // MSB first
					slowControlParameter[MicrorocPkg::slowControlLength-1-i] :
					readScopeChannel[MicrorocPkg::readScopeLength-1-i];
				assert (captured[i] === expBit) else
					showMismatch($sformatf("SR_IN bit %0d of case %0d", i, c), expBit, captured[i]);
			end
			assert (SR_SELECT === caseSelect[c]) else
				showMismatch("SR_SELECT", caseSelect[c], SR_SELECT);
			captured.delete();                                        // Late edges land in next case
			resetPulses = 0;
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/MicrorocPkg.sv
verilog/ConfigFifoIf.sv
verilog/PulseSynchronous.sv
verilog/ParameterGenerator.sv
verilog/ConfigParameterFifo.sv
verilog/BitShiftOut.sv
verilog/SlowControlAndReadScopeSet.sv
tests/SlowControl_props.sv
tests/SlowControlTb.sv

// ==== Bender.yml ====
package:
  name: microroc_slow_control

sources:
  - files:
      - verilog/MicrorocPkg.sv
      - verilog/ConfigFifoIf.sv
      - verilog/PulseSynchronous.sv
      - verilog/ParameterGenerator.sv
      - verilog/ConfigParameterFifo.sv
      - verilog/BitShiftOut.sv
      - verilog/SlowControlAndReadScopeSet.sv
  - target: test
    files:
      - tests/SlowControl_props.sv
      - tests/SlowControlTb.sv
